/* common/neopixel_pkg.sv */
package neopixel_pkg;

    // OBI and FIFO word geometry
    localparam int unsigned DataWidth = 32;
    localparam int unsigned AddrWidth = 32;

    // Byte count of a transfer command
    localparam int unsigned LenWidth = 16;

    // Word count derived from the byte count, low two bits dropped
    localparam int unsigned WordCntWidth = LenWidth - 2;

    // Word FIFO between DMA and serializer
    localparam int unsigned FifoDepth = 4;
    localparam int unsigned PtrWidth = $clog2(FifoDepth);
    localparam int unsigned LevelWidth = $clog2(FifoDepth + 1);

    // Outstanding OBI reads
    localparam int unsigned MaxInFlight = 2;
    localparam int unsigned InFlightWidth = $clog2(MaxInFlight + 1);

    // One GRB pixel per word
    localparam int unsigned PixelBits = 24;
    localparam int unsigned BitIdxWidth = $clog2(PixelBits);

    // Waveform timing in clock cycles, shortened for simulation
    localparam int unsigned BitCycles = 10;
    localparam int unsigned T0HighCycles = 3;
    localparam int unsigned T1HighCycles = 7;
    localparam int unsigned CycWidth = $clog2(BitCycles);

    // Low time that makes the strip latch its shifted data
    localparam int unsigned LatchCycles = 50;
    localparam int unsigned LatchCntWidth = $clog2(LatchCycles);

endpackage

/* hdl/neopixel_dma.sv */
module neopixel_dma (
    input  logic                                  clk_i,
    input  logic                                  arst_n_i,
    // Transfer command
    input  logic [neopixel_pkg::AddrWidth-1:0]    src_addr_i,
    input  logic [neopixel_pkg::LenWidth-1:0]     num_bytes_i,
    input  logic                                  req_valid_i,
    output logic                                  req_ready_o,
    output logic                                  transfer_done_o,
    output logic                                  busy_o,
    // OBI read port
    output logic                                  obi_req_o,
    output logic [neopixel_pkg::AddrWidth-1:0]    obi_addr_o,
    input  logic                                  obi_gnt_i,
    input  logic                                  obi_rvalid_i,
    input  logic [neopixel_pkg::DataWidth-1:0]    obi_rdata_i,
    // Word FIFO write side
    output logic [neopixel_pkg::DataWidth-1:0]    wr_data_o,
    output logic                                  wr_valid_o,
    input  logic                                  wr_ready_i,
    input  logic [neopixel_pkg::LevelWidth-1:0]   fifo_level_i
);

    localparam int unsigned SumWidth = neopixel_pkg::LevelWidth + 1;

    logic                                    busy_q;
    logic [neopixel_pkg::AddrWidth-1:0]      addr_q;
    logic [neopixel_pkg::WordCntWidth-1:0]   req_left_q;
    logic [neopixel_pkg::WordCntWidth-1:0]   rsp_left_q;
    logic [neopixel_pkg::InFlightWidth-1:0]  inflight_q;
    logic [SumWidth-1:0]                     words_committed;
    logic                                    accept;
    logic                                    room_ok;
    logic                                    gnt_fire;
    logic                                    rsp_fire;

    assign accept = req_valid_i && req_ready_o;

    // FIFO words plus reads still on the bus must stay below the FIFO depth
    assign words_committed = SumWidth'(fifo_level_i) + SumWidth'(inflight_q);
    assign room_ok = (words_committed < SumWidth'(neopixel_pkg::FifoDepth))
                     && (inflight_q < neopixel_pkg::InFlightWidth'(neopixel_pkg::MaxInFlight));

    assign obi_req_o  = busy_q && (req_left_q != '0) && room_ok;
    assign obi_addr_o = addr_q;
    assign gnt_fire   = obi_req_o && obi_gnt_i;

    // Responses go straight into the FIFO
    assign wr_data_o  = obi_rdata_i;
    assign wr_valid_o = obi_rvalid_i;
    assign rsp_fire   = wr_valid_o && wr_ready_i;

    assign req_ready_o     = !busy_q;
    assign busy_o          = busy_q;
    assign transfer_done_o = busy_q && (rsp_left_q == '0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q     <= 1'b0;
            req_left_q <= '0;
            rsp_left_q <= '0;
            inflight_q <= '0;
        end else begin
            if (accept) begin
                busy_q     <= 1'b1;
                req_left_q <= num_bytes_i[neopixel_pkg::LenWidth-1:2];
                rsp_left_q <= num_bytes_i[neopixel_pkg::LenWidth-1:2];
            end else if (transfer_done_o) begin
                busy_q <= 1'b0;
            end else begin
                if (gnt_fire) begin
                    req_left_q <= req_left_q - 1'b1;
                end
                if (rsp_fire) begin
                    rsp_left_q <= rsp_left_q - 1'b1;
                end
            end

            // Outstanding reads
            case ({gnt_fire, rsp_fire})
                2'b10:   inflight_q <= inflight_q + 1'b1;
                2'b01:   inflight_q <= inflight_q - 1'b1;
                default: inflight_q <= inflight_q;
            endcase
        end
    end

    // Word address, only meaningful while busy
    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q <= {src_addr_i[neopixel_pkg::AddrWidth-1:2], 2'b00};
        end else if (gnt_fire) begin
            addr_q <= addr_q + neopixel_pkg::AddrWidth'(4);
        end
    end

endmodule

/* hdl/neopixel_word_fifo.sv */
module neopixel_word_fifo (
    input  logic                                  clk_i,
    input  logic                                  arst_n_i,
    // Write side
    input  logic [neopixel_pkg::DataWidth-1:0]    wr_data_i,
    input  logic                                  wr_valid_i,
    output logic                                  wr_ready_o,
    // Read side
    output logic [neopixel_pkg::DataWidth-1:0]    rd_data_o,
    output logic                                  rd_valid_o,
    input  logic                                  rd_ready_i,
    // Fill count
    output logic [neopixel_pkg::LevelWidth-1:0]   level_o
);

    logic [neopixel_pkg::DataWidth-1:0]   mem_q [neopixel_pkg::FifoDepth];
    logic [neopixel_pkg::PtrWidth-1:0]    wr_ptr_q;
    logic [neopixel_pkg::PtrWidth-1:0]    rd_ptr_q;
    logic [neopixel_pkg::LevelWidth-1:0]  count_q;
    logic                                 push;
    logic                                 pop;

    assign wr_ready_o = count_q != neopixel_pkg::LevelWidth'(neopixel_pkg::FifoDepth);
    assign rd_valid_o = count_q != '0;
    assign rd_data_o  = mem_q[rd_ptr_q];
    assign level_o    = count_q;

    assign push = wr_valid_i && wr_ready_o;
    assign pop  = rd_valid_o && rd_ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == neopixel_pkg::PtrWidth'(neopixel_pkg::FifoDepth - 1))
                            ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == neopixel_pkg::PtrWidth'(neopixel_pkg::FifoDepth - 1))
                            ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= wr_data_i;
        end
    end

endmodule

/* neopixel/neopixel_serializer.sv */
module neopixel_serializer (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    // Word input from the FIFO
    input  logic [neopixel_pkg::DataWidth-1:0]  word_i,
    input  logic                                word_valid_i,
    output logic                                word_ready_o,
    // One-wire strip output
    output logic                                pixel_o
);

    typedef enum logic [1:0] {
        StIdle,
        StSend,
        StLatch
    } state_e;

    state_e                                    state_q;
    logic [neopixel_pkg::PixelBits-1:0]        shift_q;
    logic [neopixel_pkg::BitIdxWidth-1:0]      bit_idx_q;
    logic [neopixel_pkg::CycWidth-1:0]         cyc_q;
    logic [neopixel_pkg::LatchCntWidth-1:0]    latch_q;
    logic [neopixel_pkg::CycWidth-1:0]         high_cycles;
    logic                                      bit_end;
    logic                                      word_end;
    logic                                      take;

    assign bit_end  = (state_q == StSend)
                      && (cyc_q == neopixel_pkg::CycWidth'(neopixel_pkg::BitCycles - 1));
    assign word_end = bit_end
                      && (bit_idx_q == neopixel_pkg::BitIdxWidth'(neopixel_pkg::PixelBits - 1));

    // New word only when idle or exactly at the end of the last bit
    assign word_ready_o = (state_q == StIdle) || word_end;
    assign take         = word_ready_o && word_valid_i;

    // Pulse width follows the current MSB
    assign high_cycles = shift_q[neopixel_pkg::PixelBits-1]
                         ? neopixel_pkg::CycWidth'(neopixel_pkg::T1HighCycles)
                         : neopixel_pkg::CycWidth'(neopixel_pkg::T0HighCycles);
    assign pixel_o = (state_q == StSend) && (cyc_q < high_cycles);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= StIdle;
            bit_idx_q <= '0;
            cyc_q     <= '0;
            latch_q   <= '0;
        end else begin
            case (state_q)
                StIdle: begin
                    if (take) begin
                        state_q   <= StSend;
                        bit_idx_q <= '0;
                        cyc_q     <= '0;
                    end
                end
                StSend: begin
                    if (bit_end) begin
                        cyc_q     <= '0;
                        bit_idx_q <= bit_idx_q + 1'b1;
                        if (word_end) begin
                            bit_idx_q <= '0;
                            // Starved FIFO at a word boundary latches the strip
                            if (!take) begin
                                state_q <= StLatch;
                                latch_q <= '0;
                            end
                        end
                    end else begin
                        cyc_q <= cyc_q + 1'b1;
                    end
                end
                StLatch: begin
                    if (latch_q == neopixel_pkg::LatchCntWidth'(neopixel_pkg::LatchCycles - 1)) begin
                        state_q <= StIdle;
                    end else begin
                        latch_q <= latch_q + 1'b1;
                    end
                end
                default: state_q <= StIdle;
            endcase
        end
    end

    // Pixel bits, MSB goes out first
    always_ff @(posedge clk_i) begin
        if (take) begin
            shift_q <= word_i[neopixel_pkg::PixelBits-1:0];
        end else if (bit_end) begin
            shift_q <= {shift_q[neopixel_pkg::PixelBits-2:0], 1'b0};
        end
    end

endmodule

/* hdl/neopixel_subsys.sv */
module neopixel_subsys (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    // Transfer command
    input  logic [neopixel_pkg::AddrWidth-1:0]  src_addr_i,
    input  logic [neopixel_pkg::LenWidth-1:0]   num_bytes_i,
    input  logic                                req_valid_i,
    output logic                                req_ready_o,
    output logic                                transfer_done_o,
    output logic                                busy_o,
    // OBI read port
    output logic                                obi_req_o,
    output logic [neopixel_pkg::AddrWidth-1:0]  obi_addr_o,
    input  logic                                obi_gnt_i,
    input  logic                                obi_rvalid_i,
    input  logic [neopixel_pkg::DataWidth-1:0]  obi_rdata_i,
    // Strip data line
    output logic                                pixel_o
);

    logic [neopixel_pkg::DataWidth-1:0]   wr_data;
    logic                                 wr_valid;
    logic                                 wr_ready;
    logic [neopixel_pkg::DataWidth-1:0]   rd_data;
    logic                                 rd_valid;
    logic                                 rd_ready;
    logic [neopixel_pkg::LevelWidth-1:0]  fifo_level;

    neopixel_dma i_dma (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .src_addr_i      (src_addr_i),
        .num_bytes_i     (num_bytes_i),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .transfer_done_o (transfer_done_o),
        .busy_o          (busy_o),
        .obi_req_o       (obi_req_o),
        .obi_addr_o      (obi_addr_o),
        .obi_gnt_i       (obi_gnt_i),
        .obi_rvalid_i    (obi_rvalid_i),
        .obi_rdata_i     (obi_rdata_i),
        .wr_data_o       (wr_data),
        .wr_valid_o      (wr_valid),
        .wr_ready_i      (wr_ready),
        .fifo_level_i    (fifo_level)
    );

    neopixel_word_fifo i_fifo (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .wr_data_i  (wr_data),
        .wr_valid_i (wr_valid),
        .wr_ready_o (wr_ready),
        .rd_data_o  (rd_data),
        .rd_valid_o (rd_valid),
        .rd_ready_i (rd_ready),
        .level_o    (fifo_level)
    );

    neopixel_serializer i_serializer (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .word_i       (rd_data),
        .word_valid_i (rd_valid),
        .word_ready_o (rd_ready),
        .pixel_o      (pixel_o)
    );

endmodule

/* bench/obi_mem_model.sv */
module obi_mem_model (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                req_i,
    input  logic [neopixel_pkg::AddrWidth-1:0]  addr_i,
    output logic                                gnt_o,
    output logic                                rvalid_o,
    output logic [neopixel_pkg::DataWidth-1:0]  rdata_o
);

    localparam int unsigned Words = 256;
    localparam int unsigned IdxWidth = $clog2(Words);

    // Loaded by the testbench before the first transfer
    logic [neopixel_pkg::DataWidth-1:0]  mem [Words];

    logic [1:0]                          stall_q;
    logic [1:0]                          delay_q;
    logic [neopixel_pkg::DataWidth-1:0]  pending [$];

    // Grant once the request has waited its drawn delay
    assign gnt_o = req_i && (stall_q == delay_q);

    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stall_q  <= '0;
            delay_q  <= '0;
            rvalid_o <= 1'b0;
            rdata_o  <= '0;
            pending.delete();
        end else begin
            // Only reads granted in earlier cycles can answer here
            if ((pending.size() > 0) && ($urandom_range(3, 0) != 0)) begin
                rvalid_o <= 1'b1;
                rdata_o  <= pending.pop_front();
            end else begin
                rvalid_o <= 1'b0;
            end
            if (gnt_o) begin
                pending.push_back(mem[addr_i[IdxWidth+1:2]]);
                stall_q <= '0;
                delay_q <= 2'($urandom_range(3, 0));
            end else if (req_i) begin
                stall_q <= stall_q + 1'b1;
            end
        end
    end

endmodule

/* bench/tb_neopixel_subsys.sv */
module tb_neopixel_subsys;

    localparam int unsigned MemWords = 256;
    localparam int unsigned MemIdxWidth = $clog2(MemWords);
    localparam int unsigned TimeoutCycles = 20000;

    typedef struct packed {
        logic [neopixel_pkg::AddrWidth-1:0]  addr;
        logic [neopixel_pkg::LenWidth-1:0]   num_bytes;
        logic [31:0]                         pixels;
    } xfer_t;

    logic                                clk_i;
    logic                                arst_n_i;
    logic [neopixel_pkg::AddrWidth-1:0]  src_addr_i;
    logic [neopixel_pkg::LenWidth-1:0]   num_bytes_i;
    logic                                req_valid_i;
    logic                                req_ready_o;
    logic                                transfer_done_o;
    logic                                busy_o;
    logic                                obi_req_o;
    logic [neopixel_pkg::AddrWidth-1:0]  obi_addr_o;
    logic                                obi_gnt_i;
    logic                                obi_rvalid_i;
    logic [neopixel_pkg::DataWidth-1:0]  obi_rdata_i;
    logic                                pixel_o;

    logic [neopixel_pkg::DataWidth-1:0]  ref_words [MemWords];
    xfer_t                               xfers [6];
    logic [neopixel_pkg::PixelBits-1:0]  rx_pixels [$];
    logic [neopixel_pkg::PixelBits-1:0]  cur_pix;
    logic [neopixel_pkg::AddrWidth-1:0]  exp_addr;
    logic                                line_q;
    int unsigned                         high_run;
    int unsigned                         low_run;
    int unsigned                         since_rise;
    int unsigned                         bit_cnt;
    int unsigned                         rise_cnt;
    int unsigned                         grant_cnt;
    int unsigned                         req_cnt;
    int unsigned                         done_cnt;

    neopixel_subsys neopixel_subsys_i (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .src_addr_i      (src_addr_i),
        .num_bytes_i     (num_bytes_i),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .transfer_done_o (transfer_done_o),
        .busy_o          (busy_o),
        .obi_req_o       (obi_req_o),
        .obi_addr_o      (obi_addr_o),
        .obi_gnt_i       (obi_gnt_i),
        .obi_rvalid_i    (obi_rvalid_i),
        .obi_rdata_i     (obi_rdata_i),
        .pixel_o         (pixel_o)
    );

    obi_mem_model obi_mem_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (obi_req_o),
        .addr_i   (obi_addr_o),
        .gnt_o    (obi_gnt_i),
        .rvalid_o (obi_rvalid_i),
        .rdata_o  (obi_rdata_i)
    );

    always #4 clk_i = ~clk_i;

    task automatic stop_on_error();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        stop_on_error();
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    // Bus activity counters, granted addresses walk up word by word
    always @(posedge clk_i) begin
        if (obi_req_o && obi_gnt_i) begin
            check_value("obi_addr_o", obi_addr_o, exp_addr);
            exp_addr = exp_addr + 32'd4;
            grant_cnt++;
        end
        if (obi_req_o) begin
            req_cnt++;
        end
        if (transfer_done_o) begin
            done_cnt++;
        end
    end

    // Line decoder, one sample of pixel_o per clock
    always @(posedge clk_i) begin
        if (!arst_n_i) begin
            line_q     = 1'b0;
            high_run   = 0;
            low_run    = neopixel_pkg::LatchCycles;
            since_rise = 0;
            bit_cnt    = 0;
        end else begin
            if (pixel_o && !line_q) begin
                if (low_run >= neopixel_pkg::LatchCycles) begin
                    check_value("bits pending at latch", 32'(bit_cnt), 32'd0);
                end else begin
                    check_value("bit period", 32'(since_rise), 32'(neopixel_pkg::BitCycles));
                end
                rise_cnt++;
                high_run   = 0;
                since_rise = 0;
            end
            if (!pixel_o && line_q) begin
                if (high_run == neopixel_pkg::T1HighCycles) begin
                    cur_pix = {cur_pix[neopixel_pkg::PixelBits-2:0], 1'b1};
                end else if (high_run == neopixel_pkg::T0HighCycles) begin
                    cur_pix = {cur_pix[neopixel_pkg::PixelBits-2:0], 1'b0};
                end else begin
                    fail_run($sformatf("pixel_o was high for %0d cycles, no valid bit", high_run));
                end
                bit_cnt++;
                if (bit_cnt == neopixel_pkg::PixelBits) begin
                    rx_pixels.push_back(cur_pix);
                    bit_cnt = 0;
                end
                low_run = 0;
            end
            if (pixel_o) begin
                high_run++;
            end else begin
                low_run++;
            end
            since_rise++;
            line_q = pixel_o;
        end
    end

    task automatic wait_accept();
        int unsigned t;
        t = 0;
        do begin
            @(posedge clk_i);
            t++;
            if (t > TimeoutCycles) begin
                fail_run("timed out waiting for the command to be accepted");
            end
        end while (!req_ready_o);
    endtask

    // busy_o must hold until the done pulse
    task automatic wait_done();
        int unsigned t;
        t = 0;
        do begin
            @(posedge clk_i);
            t++;
            if (t > TimeoutCycles) begin
                fail_run("timed out waiting for transfer_done_o");
            end
            check_value("busy_o during transfer", 32'(busy_o), 32'd1);
        end while (!transfer_done_o);
    endtask

    task automatic wait_pixels(input int unsigned count);
        int unsigned t;
        t = 0;
        while (rx_pixels.size() < count) begin
            @(posedge clk_i);
            t++;
            if (t > TimeoutCycles) begin
                fail_run("timed out waiting for pixels on the line");
            end
        end
    endtask

    task automatic wait_latch();
        int unsigned t;
        t = 0;
        while (low_run < neopixel_pkg::LatchCycles) begin
            @(posedge clk_i);
            t++;
            if (t > TimeoutCycles) begin
                fail_run("timed out waiting for the latch period");
            end
        end
    endtask

    initial begin
        logic [MemIdxWidth-1:0]              idx;
        logic [neopixel_pkg::PixelBits-1:0]  got;
        int unsigned                         grants0;
        int unsigned                         reqs0;
        int unsigned                         dones0;
        int unsigned                         rises0;

        clk_i       = 1'b0;
        arst_n_i    = 1'b0;
        src_addr_i  = '0;
        num_bytes_i = '0;
        req_valid_i = 1'b0;
        exp_addr    = '0;
        void'($urandom(32'h234a));

        // Random memory image, a copy stays here for the expected pixels
        idx = '0;
        repeat (MemWords) begin
            ref_words[idx]     = $urandom;
            obi_mem_i.mem[idx] = ref_words[idx];
            idx++;
        end

        // Start address, byte count, pixels expected
        xfers[0] = '{32'h0000_0000, 16'd12, 32'd3};
        xfers[1] = '{32'h0000_0040, 16'd0, 32'd0};
        xfers[2] = '{32'h0000_0104, 16'd40, 32'd10};
        xfers[3] = '{32'h0000_03f0, 16'd16, 32'd4};
        xfers[4] = '{32'h0000_0200, 16'd6, 32'd1};
        xfers[5] = '{32'h0000_0080, 16'd4, 32'd1};

        repeat (10) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(posedge clk_i);
        check_value("req_ready_o after reset", 32'(req_ready_o), 32'd1);
        check_value("busy_o after reset", 32'(busy_o), 32'd0);
        check_value("transfer_done_o after reset", 32'(transfer_done_o), 32'd0);
        check_value("obi_req_o after reset", 32'(obi_req_o), 32'd0);
        check_value("pixel_o after reset", 32'(pixel_o), 32'd0);

        foreach (xfers[n]) begin
            grants0  = grant_cnt;
            reqs0    = req_cnt;
            dones0   = done_cnt;
            rises0   = rise_cnt;
            exp_addr = {xfers[n].addr[neopixel_pkg::AddrWidth-1:2], 2'b00};
            src_addr_i  <= xfers[n].addr;
            num_bytes_i <= xfers[n].num_bytes;
            req_valid_i <= 1'b1;
            wait_accept();
            req_valid_i <= 1'b0;
            wait_done();
            @(posedge clk_i);
            check_value("busy_o after transfer_done_o", 32'(busy_o), 32'd0);
            wait_pixels(xfers[n].pixels);
            wait_latch();

            check_value("pixel count", 32'(rx_pixels.size()), xfers[n].pixels);
            idx = xfers[n].addr[MemIdxWidth+1:2];
            repeat (xfers[n].pixels) begin
                got = rx_pixels.pop_front();
                check_value("pixel", 32'(got), 32'(ref_words[idx][neopixel_pkg::PixelBits-1:0]));
                idx++;
            end
            check_value("transfer_done_o pulses", done_cnt - dones0, 32'd1);
            check_value("OBI grants", grant_cnt - grants0, 32'(xfers[n].num_bytes >> 2));
            if ((xfers[n].num_bytes >> 2) == '0) begin
                check_value("OBI request cycles", req_cnt - reqs0, 32'd0);
                check_value("rising edges on pixel_o", rise_cnt - rises0, 32'd0);
            end
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* all.f */
common/neopixel_pkg.sv
hdl/neopixel_dma.sv
hdl/neopixel_word_fifo.sv
neopixel/neopixel_serializer.sv
hdl/neopixel_subsys.sv
bench/obi_mem_model.sv
bench/tb_neopixel_subsys.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the NeoPixel subsystem testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f all.f --top-module tb_neopixel_subsys -o tb_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_sim; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without errors"
exit 0
